/* tb.f */
src/nabp_cfg_pkg.sv
src/nabp_ctrl_pkg.sv
src/nabp_wb_regs.sv
src/nabp_swap_control.sv
src/nabp_state_control.sv
src/nabp_shifter.sv
src/nabp_mapper.sv
src/nabp_top.sv
sim/nabp_chk.sv
sim/nabp_tb.sv

/* Makefile */
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "make clean  remove obj_dir and $(LOG)"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert --top-module nabp_tb -f tb.f -o nabp_sim
	./obj_dir/nabp_sim > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Everything OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* sim/nabp_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module nabp_tb;

    localparam int ack_limit   = 16;
    localparam int poll_limit  = 200;
    localparam int check_limit = 5000;
    localparam int line_w      = nabp_cfg_pkg::line_len * nabp_cfg_pkg::sample_w;

    logic clk;
    logic reset_n;
    logic cyc;
    logic stb;
    logic we;
    logic [nabp_cfg_pkg::wb_adr_w-1:0] adr;
    logic [nabp_cfg_pkg::wb_dat_w-1:0] dat_w;
    logic [nabp_cfg_pkg::wb_dat_w-1:0] dat_r;
    logic ack;

    logic [31:0] lfsr;
    logic [nabp_cfg_pkg::accu_w-1:0] exp_accu [nabp_cfg_pkg::n_pix];
    logic check_req;

    nabp_top u_nabp_top (
        .clk, .reset_n, .cyc, .stb, .we, .adr, .dat_w, .dat_r, .ack
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic compare_accu(input int p,
                                input logic [nabp_cfg_pkg::accu_w-1:0] got,
                                input logic [nabp_cfg_pkg::accu_w-1:0] exp);
        if (got !== exp)
            stop_run($sformatf("[FAIL] %0t accu[%0d]: got %h, expected %h",
                               $time, p, got, exp));
    endtask

    task automatic compare_status(input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp)
            stop_run($sformatf("[FAIL] %0t status: got %b, expected %b",
                               $time, got, exp));
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [line_w-1:0] random_line();
        logic [line_w-1:0] v;
        for (int i = 0; i < nabp_cfg_pkg::line_len; i++)
            v[i*nabp_cfg_pkg::sample_w +: nabp_cfg_pkg::sample_w] =
                nabp_cfg_pkg::sample_w'(take_bits(nabp_cfg_pkg::sample_w));
        return v;
    endfunction

    // running total of pixel p after one more iteration
    function automatic logic [nabp_cfg_pkg::accu_w-1:0] pixel_sum(
        input logic [nabp_cfg_pkg::accu_w-1:0] prev,
        input int p,
        input logic [line_w-1:0] samples,
        input logic [nabp_cfg_pkg::idx_w-1:0] sh,
        input logic [nabp_cfg_pkg::idx_w-1:0] init,
        input logic [nabp_cfg_pkg::idx_w-1:0] base
    );
        int target;
        int off;
        logic [nabp_cfg_pkg::accu_w-1:0] sum;
        sum = prev;
        target = (int'(init) + p * int'(base)) % nabp_cfg_pkg::line_len;
        // distance past the window start, wrapped
        off = (target - int'(sh) + nabp_cfg_pkg::line_len) % nabp_cfg_pkg::line_len;
        if (off < nabp_cfg_pkg::n_shift)
            sum = sum + nabp_cfg_pkg::accu_w'(
                samples[target*nabp_cfg_pkg::sample_w +: nabp_cfg_pkg::sample_w]);
        return sum;
    endfunction

    task automatic write_word(input logic [nabp_cfg_pkg::wb_adr_w-1:0] a,
                              input logic [nabp_cfg_pkg::wb_dat_w-1:0] d);
        int n;
        n = 0;
        cyc = 1'b1;
        stb = 1'b1;
        we = 1'b1;
        adr = a;
        dat_w = d;
        do
        begin
            @(posedge clk);
            #1;
            n++;
            if (n > ack_limit)
                stop_run("bus write got no ack");
        end
        while (!ack);
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
    endtask

    task automatic read_word(input logic [nabp_cfg_pkg::wb_adr_w-1:0] a,
                             output logic [nabp_cfg_pkg::wb_dat_w-1:0] d);
        int n;
        n = 0;
        cyc = 1'b1;
        stb = 1'b1;
        we = 1'b0;
        adr = a;
        do
        begin
            @(posedge clk);
            #1;
            n++;
            if (n > ack_limit)
                stop_run("bus read got no ack");
        end
        while (!ack);
        d = dat_r;
        cyc = 1'b0;
        stb = 1'b0;
    endtask

    task automatic issue_cmd(input nabp_ctrl_pkg::cmd_t c);
        write_word(nabp_cfg_pkg::adr_cmd, 32'(c));
    endtask

    task automatic write_line(input logic [line_w-1:0] samples);
        for (int i = 0; i < nabp_cfg_pkg::line_len; i++)
            write_word(nabp_cfg_pkg::adr_sample_base + nabp_cfg_pkg::wb_adr_w'(i),
                       32'(samples[i*nabp_cfg_pkg::sample_w +: nabp_cfg_pkg::sample_w]));
    endtask

    task automatic write_params(input logic [nabp_cfg_pkg::idx_w-1:0] sh,
                                input logic [nabp_cfg_pkg::idx_w-1:0] init,
                                input logic [nabp_cfg_pkg::idx_w-1:0] base);
        write_word(nabp_cfg_pkg::adr_sh_base, 32'(sh));
        write_word(nabp_cfg_pkg::adr_mp_init, 32'(init));
        write_word(nabp_cfg_pkg::adr_mp_base, 32'(base));
    endtask

    // poll until neither busy nor pending
    task automatic wait_idle();
        logic [nabp_cfg_pkg::wb_dat_w-1:0] word;
        int n;
        n = 0;
        do
        begin
            read_word(nabp_cfg_pkg::adr_status, word);
            n++;
            if (n > poll_limit)
                stop_run("iteration never finished, busy or pending stuck high");
        end
        while (word[1:0] != 2'b00);
    endtask

    // pending drops once the bank has flipped
    task automatic wait_swap();
        logic [nabp_cfg_pkg::wb_dat_w-1:0] word;
        int n;
        n = 0;
        do
        begin
            read_word(nabp_cfg_pkg::adr_status, word);
            n++;
            if (n > poll_limit)
                stop_run("pending run was never taken");
        end
        while (word[1] != 1'b0);
    endtask

    task automatic expect_iteration(input logic [line_w-1:0] samples,
                                    input logic [nabp_cfg_pkg::idx_w-1:0] sh,
                                    input logic [nabp_cfg_pkg::idx_w-1:0] init,
                                    input logic [nabp_cfg_pkg::idx_w-1:0] base);
        for (int p = 0; p < nabp_cfg_pkg::n_pix; p++)
            exp_accu[p] = pixel_sum(exp_accu[p], p, samples, sh, init, base);
    endtask

    task automatic run_iteration(input logic [line_w-1:0] samples,
                                 input logic [nabp_cfg_pkg::idx_w-1:0] sh,
                                 input logic [nabp_cfg_pkg::idx_w-1:0] init,
                                 input logic [nabp_cfg_pkg::idx_w-1:0] base);
        write_line(samples);
        write_params(sh, init, base);
        issue_cmd(nabp_ctrl_pkg::cmd_run);
        wait_idle();
        expect_iteration(samples, sh, init, base);
    endtask

    // hand the bus to the comparing process and wait for it
    task automatic request_check();
        int n;
        n = 0;
        check_req = 1'b1;
        while (check_req)
        begin
            @(posedge clk);
            #1;
            n++;
            if (n > check_limit)
                stop_run("comparing process did not finish");
        end
    endtask

    initial
    begin : comparer
        logic [nabp_cfg_pkg::wb_dat_w-1:0] word;
        int n;
        forever
        begin
            n = 0;
            do
            begin
                @(posedge clk);
                #1;
                n++;
                if (n > check_limit)
                    stop_run("no check requested for too long");
            end
            while (check_req !== 1'b1);
            read_word(nabp_cfg_pkg::adr_status, word);
            compare_status(word[1:0], 2'b00);
            for (int p = 0; p < nabp_cfg_pkg::n_pix; p++)
            begin
                read_word(nabp_cfg_pkg::adr_accu_base + nabp_cfg_pkg::wb_adr_w'(p), word);
                compare_accu(p, word[nabp_cfg_pkg::accu_w-1:0], exp_accu[p]);
            end
            check_req = 1'b0;
        end
    end

    initial
    begin : stimulus
        logic [line_w-1:0] samples;
        logic [nabp_cfg_pkg::idx_w-1:0] sh;
        logic [nabp_cfg_pkg::idx_w-1:0] init;
        logic [nabp_cfg_pkg::idx_w-1:0] base;
        lfsr = 32'h992d_e513;
        reset_n = 1'b0;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        adr = '0;
        dat_w = '0;
        check_req = 1'b0;
        for (int p = 0; p < nabp_cfg_pkg::n_pix; p++)
            exp_accu[p] = '0;
        repeat (3) @(posedge clk);
        #1;
        reset_n = 1'b1;

        // idle state straight out of reset
        request_check();

        // one iteration, then a few more on top of the running totals
        for (int k = 0; k < 5; k++)
        begin
            samples = random_line();
            sh = nabp_cfg_pkg::idx_w'(take_bits(nabp_cfg_pkg::idx_w));
            init = nabp_cfg_pkg::idx_w'(take_bits(nabp_cfg_pkg::idx_w));
            base = nabp_cfg_pkg::idx_w'(take_bits(nabp_cfg_pkg::idx_w));
            run_iteration(samples, sh, init, base);
            request_check();
        end

        // window 6 7 0 1, targets 6 1 4 7
        samples = random_line();
        run_iteration(samples, 3'd6, 3'd6, 3'd3);
        request_check();

        // first run of the pair, released as soon as its line is taken
        samples = random_line();
        sh = nabp_cfg_pkg::idx_w'(take_bits(nabp_cfg_pkg::idx_w));
        init = nabp_cfg_pkg::idx_w'(take_bits(nabp_cfg_pkg::idx_w));
        base = nabp_cfg_pkg::idx_w'(take_bits(nabp_cfg_pkg::idx_w));
        write_line(samples);
        write_params(sh, init, base);
        issue_cmd(nabp_ctrl_pkg::cmd_run);
        wait_swap();
        expect_iteration(samples, sh, init, base);

        // next line and parameters go in while the first run is still shifting
        samples = random_line();
        sh = nabp_cfg_pkg::idx_w'(take_bits(nabp_cfg_pkg::idx_w));
        init = nabp_cfg_pkg::idx_w'(take_bits(nabp_cfg_pkg::idx_w));
        base = nabp_cfg_pkg::idx_w'(take_bits(nabp_cfg_pkg::idx_w));
        write_line(samples);
        write_params(sh, init, base);
        issue_cmd(nabp_ctrl_pkg::cmd_run);
        wait_idle();
        expect_iteration(samples, sh, init, base);
        request_check();

        // clear, then start over from zero
        issue_cmd(nabp_ctrl_pkg::cmd_clear);
        for (int p = 0; p < nabp_cfg_pkg::n_pix; p++)
            exp_accu[p] = '0;
        request_check();
        samples = random_line();
        run_iteration(samples, 3'd2, 3'd1, 3'd1);
        request_check();

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

/* sim/nabp_chk.sv */
`timescale 1ns/100ps
`default_nettype none

module nabp_chk
(
    input wire clk,
    input wire reset_n,
    input wire stb,
    input wire ack,
    input wire sh_fill_kick,
    input wire sh_shift_kick,
    input wire sw_swap
);

    // one ack per request, never held while the master still strobes
    ack_single: assert property (@(posedge clk) disable iff (!reset_n)
        (ack && stb) |=> !ack)
        else $error("ack high for two cycles with stb held");

    // fill and shift are entered on different transitions
    kick_excl: assert property (@(posedge clk) disable iff (!reset_n)
        !(sh_fill_kick && sh_shift_kick))
        else $error("fill and shift kicks high together");

    swap_in_reset: assert property (@(posedge clk)
        !reset_n |=> !sw_swap)
        else $error("sw_swap high while in reset");

endmodule

bind nabp_top nabp_chk u_chk (
    .clk(clk),
    .reset_n(reset_n),
    .stb(stb),
    .ack(ack),
    .sh_fill_kick(sh_fill_kick),
    .sh_shift_kick(sh_shift_kick),
    .sw_swap(sw_swap)
);

`default_nettype wire

/* src/nabp_top.sv */
`timescale 1ns/100ps
`default_nettype none

module nabp_top
(
    input wire clk,
    input wire reset_n,
    input wire cyc,
    input wire stb,
    input wire we,
    input wire [nabp_cfg_pkg::wb_adr_w-1:0] adr,
    input wire [nabp_cfg_pkg::wb_dat_w-1:0] dat_w,
    output logic [nabp_cfg_pkg::wb_dat_w-1:0] dat_r,
    output logic ack
);

    logic sample_we;
    logic [nabp_cfg_pkg::idx_w-1:0] sample_idx;
    logic [nabp_cfg_pkg::sample_w-1:0] sample_data;
    logic param_we;
    logic [nabp_cfg_pkg::idx_w-1:0] sh_base;
    logic [nabp_cfg_pkg::idx_w-1:0] mp_init;
    logic [nabp_cfg_pkg::idx_w-1:0] mp_base;
    logic run_req;
    logic clear;
    logic busy;
    logic pending;
    logic bank_sel;
    logic [nabp_cfg_pkg::idx_w-1:0] sw_sh_accu_base;
    logic [nabp_cfg_pkg::idx_w-1:0] sw_mp_accu_init;
    logic [nabp_cfg_pkg::idx_w-1:0] sw_mp_accu_base;
    logic sw_next_itr_ack;
    logic sw_swap_ack;
    logic sw_next_itr;
    logic sw_swap;
    logic sh_fill_kick;
    logic sh_shift_kick;
    logic sh_fill_done;
    logic sh_shift_done;
    logic [nabp_cfg_pkg::idx_w-1:0] sh_accu_base;
    logic [nabp_cfg_pkg::idx_w-1:0] mp_accu_init;
    logic [nabp_cfg_pkg::idx_w-1:0] mp_accu_base;
    logic bc_valid;
    logic [nabp_cfg_pkg::idx_w-1:0] bc_idx;
    logic [nabp_cfg_pkg::sample_w-1:0] bc_sample;
    logic [nabp_cfg_pkg::n_pix*nabp_cfg_pkg::accu_w-1:0] accu;

    nabp_wb_regs u_wb_regs (
        .clk, .reset_n, .cyc, .stb, .we, .adr, .dat_w, .busy, .pending, .accu,
        .dat_r, .ack, .sample_we, .sample_idx, .sample_data, .param_we,
        .sh_base, .mp_init, .mp_base, .run_req, .clear
    );

    nabp_swap_control u_swap_control (
        .clk, .reset_n, .param_we, .sh_base, .mp_init, .mp_base, .run_req,
        .sw_next_itr, .sw_swap, .sw_sh_accu_base, .sw_mp_accu_init,
        .sw_mp_accu_base, .sw_next_itr_ack, .sw_swap_ack, .pending, .bank_sel
    );

    nabp_state_control u_state_control (
        .clk, .reset_n, .sw_sh_accu_base, .sw_mp_accu_init, .sw_mp_accu_base,
        .sw_swap_ack, .sw_next_itr_ack, .sh_fill_done, .sh_shift_done,
        .sw_swap, .sw_next_itr, .sh_fill_kick, .sh_shift_kick, .sh_accu_base,
        .mp_accu_init, .mp_accu_base, .busy
    );

    nabp_shifter u_shifter (
        .clk, .reset_n, .sample_we, .sample_idx, .sample_data, .bank_sel,
        .sh_fill_kick, .sh_shift_kick, .sh_accu_base, .sh_fill_done,
        .sh_shift_done, .bc_valid, .bc_idx, .bc_sample
    );

    // one mapper per pixel, each drains into its slice of the accu bus
    for (genvar i = 0; i < nabp_cfg_pkg::n_pix; i++)
    begin : g_mapper
        nabp_mapper #(.pix(i)) u_mapper (
            .clk, .reset_n, .clear, .mp_accu_init, .mp_accu_base,
            .bc_valid, .bc_idx, .bc_sample,
            .accu(accu[i*nabp_cfg_pkg::accu_w +: nabp_cfg_pkg::accu_w])
        );
    end

endmodule

`default_nettype wire

/* src/nabp_mapper.sv */
`timescale 1ns/100ps
`default_nettype none

module nabp_mapper
#(
    parameter int pix = 0
)
(
    input wire clk,
    input wire reset_n,
    input wire clear,
    input wire [nabp_cfg_pkg::idx_w-1:0] mp_accu_init,
    input wire [nabp_cfg_pkg::idx_w-1:0] mp_accu_base,
    input wire bc_valid,
    input wire [nabp_cfg_pkg::idx_w-1:0] bc_idx,
    input wire [nabp_cfg_pkg::sample_w-1:0] bc_sample,
    output logic [nabp_cfg_pkg::accu_w-1:0] accu
);

    localparam logic [nabp_cfg_pkg::idx_w-1:0] pix_pos = nabp_cfg_pkg::idx_w'(pix);

    logic [nabp_cfg_pkg::idx_w-1:0] target;
    logic hit;

    // target sample for this pixel, modulo line_len by truncation
    always_ff @(posedge clk)
    begin
        target <= mp_accu_init + pix_pos * mp_accu_base;
    end

    assign hit = bc_valid && (bc_idx == target);

    // accumulator wraps at accu_w
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            accu <= '0;
        else if (clear)
            accu <= '0;
        else if (hit)
            accu <= accu + nabp_cfg_pkg::accu_w'(bc_sample);
    end

endmodule

`default_nettype wire

/* src/nabp_shifter.sv */
`timescale 1ns/100ps
`default_nettype none

module nabp_shifter
(
    input wire clk,
    input wire reset_n,
    input wire sample_we,
    input wire [nabp_cfg_pkg::idx_w-1:0] sample_idx,
    input wire [nabp_cfg_pkg::sample_w-1:0] sample_data,
    input wire bank_sel,
    input wire sh_fill_kick,
    input wire sh_shift_kick,
    input wire [nabp_cfg_pkg::idx_w-1:0] sh_accu_base,
    output logic sh_fill_done,
    output logic sh_shift_done,
    output logic bc_valid,
    output logic [nabp_cfg_pkg::idx_w-1:0] bc_idx,
    output logic [nabp_cfg_pkg::sample_w-1:0] bc_sample
);

    logic [nabp_cfg_pkg::sample_w-1:0] bank [2][nabp_cfg_pkg::line_len];
    logic [nabp_cfg_pkg::sample_w-1:0] line [nabp_cfg_pkg::line_len];
    logic fill_act;
    logic shift_act;
    logic [nabp_cfg_pkg::idx_w-1:0] fill_cnt;
    logic [nabp_cfg_pkg::idx_w-1:0] shift_cnt;
    logic [nabp_cfg_pkg::idx_w-1:0] win_idx;

    // window index wraps modulo line_len through the index width
    assign win_idx = sh_accu_base + shift_cnt;

    // host side writes and working line copy
    // the host always writes the bank not named by bank_sel,
    // fill runs before the swap so it takes that same bank
    always_ff @(posedge clk)
    begin
        if (sample_we)
            bank[~bank_sel][sample_idx] <= sample_data;
        if (fill_act)
            line[fill_cnt] <= bank[~bank_sel][fill_cnt];
        bc_idx    <= win_idx;
        bc_sample <= line[win_idx];
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            fill_act      <= 1'b0;
            shift_act     <= 1'b0;
            fill_cnt      <= '0;
            shift_cnt     <= '0;
            sh_fill_done  <= 1'b0;
            sh_shift_done <= 1'b0;
            bc_valid      <= 1'b0;
        end
        else
        begin
            sh_fill_done  <= 1'b0;
            sh_shift_done <= 1'b0;
            bc_valid      <= shift_act;
            if (sh_fill_kick)
            begin
                fill_act <= 1'b1;
                fill_cnt <= '0;
            end
            else if (fill_act)
            begin
                fill_cnt <= fill_cnt + 1'b1;
                if (fill_cnt == nabp_cfg_pkg::idx_w'(nabp_cfg_pkg::line_len - 1))
                begin
                    fill_act     <= 1'b0;
                    sh_fill_done <= 1'b1;
                end
            end
            if (sh_shift_kick)
            begin
                shift_act <= 1'b1;
                shift_cnt <= '0;
            end
            else if (shift_act)
            begin
                shift_cnt <= shift_cnt + 1'b1;
                // done lines up with the last broadcast beat
                if (shift_cnt == nabp_cfg_pkg::idx_w'(nabp_cfg_pkg::n_shift - 1))
                begin
                    shift_act     <= 1'b0;
                    sh_shift_done <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* src/nabp_state_control.sv */
`timescale 1ns/100ps
`default_nettype none

module nabp_state_control
(
    input wire clk,
    input wire reset_n,
    // from swap control
    input wire [nabp_cfg_pkg::idx_w-1:0] sw_sh_accu_base,
    input wire [nabp_cfg_pkg::idx_w-1:0] sw_mp_accu_init,
    input wire [nabp_cfg_pkg::idx_w-1:0] sw_mp_accu_base,
    input wire sw_swap_ack,
    input wire sw_next_itr_ack,
    // from shifter
    input wire sh_fill_done,
    input wire sh_shift_done,
    // to swap control
    output logic sw_swap,
    output logic sw_next_itr,
    // to shifter
    output logic sh_fill_kick,
    output logic sh_shift_kick,
    output logic [nabp_cfg_pkg::idx_w-1:0] sh_accu_base,
    // to mappers
    output logic [nabp_cfg_pkg::idx_w-1:0] mp_accu_init,
    output logic [nabp_cfg_pkg::idx_w-1:0] mp_accu_base,
    output logic busy
);

    nabp_ctrl_pkg::state_t state;
    nabp_ctrl_pkg::state_t next_state;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            state <= nabp_ctrl_pkg::ready_s;
        else
            state <= next_state;
    end

    // parameters follow the pending set until the iteration leaves ready
    always_ff @(posedge clk)
    begin
        if (state == nabp_ctrl_pkg::ready_s)
        begin
            sh_accu_base <= sw_sh_accu_base;
            mp_accu_init <= sw_mp_accu_init;
            mp_accu_base <= sw_mp_accu_base;
        end
    end

    always_comb
    begin
        next_state = state;
        case (state)
            nabp_ctrl_pkg::ready_s:
                if (sw_next_itr_ack)
                    next_state = nabp_ctrl_pkg::fill_s;
            nabp_ctrl_pkg::fill_s:
                if (sh_fill_done)
                    next_state = nabp_ctrl_pkg::fill_done_s;
            nabp_ctrl_pkg::fill_done_s:
                if (sw_swap_ack)
                    next_state = nabp_ctrl_pkg::shift_s;
            nabp_ctrl_pkg::shift_s:
                if (sh_shift_done)
                    next_state = nabp_ctrl_pkg::ready_s;
            default:
                next_state = nabp_ctrl_pkg::ready_s;
        endcase
    end

    // mealy outputs, kicks fire on the entering transition
    assign sw_swap       = (state == nabp_ctrl_pkg::fill_done_s);
    assign sw_next_itr   = (state == nabp_ctrl_pkg::ready_s);
    assign sh_fill_kick  = (next_state != state) && (next_state == nabp_ctrl_pkg::fill_s);
    assign sh_shift_kick = (next_state != state) && (next_state == nabp_ctrl_pkg::shift_s);
    assign busy          = (state != nabp_ctrl_pkg::ready_s);

endmodule

`default_nettype wire

/* src/nabp_swap_control.sv */
`timescale 1ns/100ps
`default_nettype none

module nabp_swap_control
(
    input wire clk,
    input wire reset_n,
    input wire param_we,
    input wire [nabp_cfg_pkg::idx_w-1:0] sh_base,
    input wire [nabp_cfg_pkg::idx_w-1:0] mp_init,
    input wire [nabp_cfg_pkg::idx_w-1:0] mp_base,
    input wire run_req,
    input wire sw_next_itr,
    input wire sw_swap,
    output logic [nabp_cfg_pkg::idx_w-1:0] sw_sh_accu_base,
    output logic [nabp_cfg_pkg::idx_w-1:0] sw_mp_accu_init,
    output logic [nabp_cfg_pkg::idx_w-1:0] sw_mp_accu_base,
    output logic sw_next_itr_ack,
    output logic sw_swap_ack,
    output logic pending,
    output logic bank_sel
);

    // pending parameter set, refreshed on any parameter write
    always_ff @(posedge clk)
    begin
        if (param_we)
        begin
            sw_sh_accu_base <= sh_base;
            sw_mp_accu_init <= mp_init;
            sw_mp_accu_base <= mp_base;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            pending     <= 1'b0;
            sw_swap_ack <= 1'b0;
            bank_sel    <= 1'b0;
        end
        else
        begin
            // single pulse per swap request
            sw_swap_ack <= sw_swap && !sw_swap_ack;
            if (sw_swap_ack)
            begin
                // pending run is taken here; a run arriving this cycle queues up again
                pending  <= run_req;
                bank_sel <= ~bank_sel;
            end
            else if (run_req)
                pending <= 1'b1;
        end
    end

    // sequencer may start the next iteration
    assign sw_next_itr_ack = pending && sw_next_itr;

endmodule

`default_nettype wire

/* src/nabp_wb_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module nabp_wb_regs
(
    input wire clk,
    input wire reset_n,
    input wire cyc,
    input wire stb,
    input wire we,
    input wire [nabp_cfg_pkg::wb_adr_w-1:0] adr,
    input wire [nabp_cfg_pkg::wb_dat_w-1:0] dat_w,
    input wire busy,
    input wire pending,
    input wire [nabp_cfg_pkg::n_pix*nabp_cfg_pkg::accu_w-1:0] accu,
    output logic [nabp_cfg_pkg::wb_dat_w-1:0] dat_r,
    output logic ack,
    output logic sample_we,
    output logic [nabp_cfg_pkg::idx_w-1:0] sample_idx,
    output logic [nabp_cfg_pkg::sample_w-1:0] sample_data,
    output logic param_we,
    output logic [nabp_cfg_pkg::idx_w-1:0] sh_base,
    output logic [nabp_cfg_pkg::idx_w-1:0] mp_init,
    output logic [nabp_cfg_pkg::idx_w-1:0] mp_base,
    output logic run_req,
    output logic clear
);

    logic req;
    logic wr;
    logic sample_hit;
    logic accu_hit;
    logic param_hit;
    logic cmd_hit;
    logic [nabp_cfg_pkg::wb_dat_w-1:0] rd_data;

    // a new request is one not yet acknowledged
    assign req = cyc && stb && !ack;
    assign wr  = req && we;

    assign sample_hit = (adr >> nabp_cfg_pkg::idx_w) ==
                        (nabp_cfg_pkg::adr_sample_base >> nabp_cfg_pkg::idx_w);
    assign accu_hit   = (adr >> nabp_cfg_pkg::pix_w) ==
                        (nabp_cfg_pkg::adr_accu_base >> nabp_cfg_pkg::pix_w);
    assign param_hit  = (adr == nabp_cfg_pkg::adr_sh_base) ||
                        (adr == nabp_cfg_pkg::adr_mp_init) ||
                        (adr == nabp_cfg_pkg::adr_mp_base);
    assign cmd_hit    = (adr == nabp_cfg_pkg::adr_cmd);

    // read mux
    always_comb
    begin
        rd_data = '0;
        if (adr == nabp_cfg_pkg::adr_sh_base)
            rd_data[nabp_cfg_pkg::idx_w-1:0] = sh_base;
        else if (adr == nabp_cfg_pkg::adr_mp_init)
            rd_data[nabp_cfg_pkg::idx_w-1:0] = mp_init;
        else if (adr == nabp_cfg_pkg::adr_mp_base)
            rd_data[nabp_cfg_pkg::idx_w-1:0] = mp_base;
        else if (adr == nabp_cfg_pkg::adr_status)
            rd_data[1:0] = {pending, busy};
        else if (accu_hit)
            rd_data[nabp_cfg_pkg::accu_w-1:0] =
                accu[adr[nabp_cfg_pkg::pix_w-1:0]*nabp_cfg_pkg::accu_w +: nabp_cfg_pkg::accu_w];
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            ack       <= 1'b0;
            sample_we <= 1'b0;
            param_we  <= 1'b0;
            run_req   <= 1'b0;
            clear     <= 1'b0;
            sh_base   <= '0;
            mp_init   <= '0;
            mp_base   <= '0;
        end
        else
        begin
            ack       <= req;
            sample_we <= wr && sample_hit;
            param_we  <= wr && param_hit;
            run_req   <= wr && cmd_hit &&
                         (nabp_ctrl_pkg::cmd_t'(dat_w[1:0]) == nabp_ctrl_pkg::cmd_run);
            clear     <= wr && cmd_hit &&
                         (nabp_ctrl_pkg::cmd_t'(dat_w[1:0]) == nabp_ctrl_pkg::cmd_clear);
            if (wr && adr == nabp_cfg_pkg::adr_sh_base)
                sh_base <= dat_w[nabp_cfg_pkg::idx_w-1:0];
            if (wr && adr == nabp_cfg_pkg::adr_mp_init)
                mp_init <= dat_w[nabp_cfg_pkg::idx_w-1:0];
            if (wr && adr == nabp_cfg_pkg::adr_mp_base)
                mp_base <= dat_w[nabp_cfg_pkg::idx_w-1:0];
        end
    end

    // sample payload and read data travel alongside the strobes
    always_ff @(posedge clk)
    begin
        if (wr)
        begin
            sample_idx  <= adr[nabp_cfg_pkg::idx_w-1:0];
            sample_data <= dat_w[nabp_cfg_pkg::sample_w-1:0];
        end
        if (req)
            dat_r <= rd_data;
    end

endmodule

`default_nettype wire

/* src/nabp_ctrl_pkg.sv */
`default_nettype none

package nabp_ctrl_pkg;

    // iteration sequencer states
    typedef enum logic [1:0] {
        ready_s     = 2'd0,
        fill_s      = 2'd1,
        fill_done_s = 2'd2,
        shift_s     = 2'd3
    } state_t;

    // opcodes written to the command register, low two bits
    typedef enum logic [1:0] {
        cmd_run   = 2'd1,
        cmd_clear = 2'd2
    } cmd_t;

endpackage

`default_nettype wire

/* src/nabp_cfg_pkg.sv */
`default_nettype none

package nabp_cfg_pkg;

    // datapath sizes
    localparam int sample_w = 16;
    localparam int accu_w   = 24;

    // projection line and pixel array
    localparam int line_len = 8;
    localparam int idx_w    = $clog2(line_len);
    localparam int n_pix    = 4;
    localparam int pix_w    = $clog2(n_pix);
    localparam int n_shift  = 4;

    // wishbone bus, word addresses
    localparam int wb_adr_w = 5;
    localparam int wb_dat_w = 32;

    // address map
    // sample words occupy adr_sample_base .. adr_sample_base + line_len - 1
    localparam logic [wb_adr_w-1:0] adr_sample_base = 5'd0;
    localparam logic [wb_adr_w-1:0] adr_sh_base     = 5'd8;
    localparam logic [wb_adr_w-1:0] adr_mp_init     = 5'd9;
    localparam logic [wb_adr_w-1:0] adr_mp_base     = 5'd10;
    localparam logic [wb_adr_w-1:0] adr_cmd         = 5'd11;
    // bit 0 busy, bit 1 pending
    localparam logic [wb_adr_w-1:0] adr_status      = 5'd12;
    // accumulators occupy adr_accu_base .. adr_accu_base + n_pix - 1
    localparam logic [wb_adr_w-1:0] adr_accu_base   = 5'd16;

endpackage

`default_nettype wire
